// File: verilog/pcal_pkg.sv
package pcal_pkg;

    ////////////////////
    // widths
    ////////////////////
    localparam int DATA_W    = 256;
    localparam int NUM_LANES = 3;

    typedef logic [DATA_W-1:0] word_t;

    ////////////////////
    // instruction fields
    ////////////////////
    // lane operation, code 3 is invalid and gives zero
    typedef logic [1:0] op_code_t;
    localparam op_code_t OP_MUL = 2'd0;
    localparam op_code_t OP_ADD = 2'd1;
    localparam op_code_t OP_SUB = 2'd2;

    typedef logic [1:0] ins_type_t;
    localparam ins_type_t INS_CAL      = 2'd0;
    localparam ins_type_t INS_UPDT_REG = 2'd1;
    localparam ins_type_t INS_FIN      = 2'd2;

    // register codes, 12..15 read as zero
    typedef logic [3:0] reg_sel_t;
    localparam reg_sel_t SEL_X2 = 4'd0;
    localparam reg_sel_t SEL_Y2 = 4'd1;
    localparam reg_sel_t SEL_Z2 = 4'd2;
    localparam reg_sel_t SEL_T0 = 4'd3;
    localparam reg_sel_t SEL_T1 = 4'd4;
    localparam reg_sel_t SEL_T2 = 4'd5;
    localparam reg_sel_t SEL_X0 = 4'd6;
    localparam reg_sel_t SEL_Y0 = 4'd7;
    localparam reg_sel_t SEL_Z0 = 4'd8;
    localparam reg_sel_t SEL_X1 = 4'd9;
    localparam reg_sel_t SEL_Y1 = 4'd10;
    localparam reg_sel_t SEL_Z1 = 4'd11;

    typedef struct packed {
        reg_sel_t sel_a;
        reg_sel_t sel_b;
        reg_sel_t sel_r;
    } ins_cal_t;

    typedef struct packed {
        logic [7:0] unused;
        reg_sel_t   reg_id;
    } ins_updt_t;

    // low 12 bits decode as a calculation or as a register update
    typedef union packed {
        ins_cal_t  cal;
        ins_updt_t updt;
    } ins_body_u;

    typedef struct packed {
        op_code_t  op;
        ins_type_t ins_type;
        ins_body_u body;
    } ins_word_t;

    typedef struct packed {
        ins_word_t [NUM_LANES-1:0] slot;
    } ins_bundle_t;

    ////////////////////
    // lane and register block
    ////////////////////
    typedef struct packed {
        logic     start;
        op_code_t op;
        word_t    a;
        word_t    b;
    } lane_req_t;

    typedef struct packed {
        logic  done;
        word_t result;
    } lane_rsp_t;

    typedef struct packed {
        word_t x;
        word_t y;
        word_t z;
    } point_t;

    ////////////////////
    // SM2 curve
    ////////////////////
    localparam word_t SM2_P =
        256'hFFFFFFFEFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF00000000FFFFFFFFFFFFFFFF;
    localparam word_t SM2_GX =
        256'h32C4AE2C1F1981195F9904466A39C9948FE30BBFF2660BE1715A4589334C74C7;
    localparam word_t SM2_GY =
        256'hBC3736A2F4F6779C59BDCEE36B692153D0A9877CC62A474002DF32E52139F0A0;

    // one conditional subtraction, valid for v below 2*m
    function automatic word_t mod_reduce(input logic [DATA_W:0] v, input word_t m);
        logic [DATA_W:0] t;
        t = v - {1'b0, m};
        return (v >= {1'b0, m}) ? t[DATA_W-1:0] : v[DATA_W-1:0];
    endfunction

endpackage

// File: verilog/mod_mul_serial.sv
`timescale 1ns/1ps

module mod_mul_serial #(
    parameter pcal_pkg::word_t MODULUS = pcal_pkg::SM2_P
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start_i,
    input  pcal_pkg::word_t a_i,
    input  pcal_pkg::word_t b_i,
    output logic            done_o,
    output pcal_pkg::word_t prod_o
);

    localparam int W     = pcal_pkg::DATA_W;
    localparam int CNT_W = $clog2(W + 1);

    logic [CNT_W-1:0] cnt_q;
    logic             busy_q;
    pcal_pkg::word_t  a_sh_q;
    pcal_pkg::word_t  b_q;
    pcal_pkg::word_t  acc_q;
    pcal_pkg::word_t  dbl_mod;
    pcal_pkg::word_t  acc_nxt;

    ////////////////////
    // one step from the msb down
    ////////////////////
    // 2*acc mod m and then + b mod m when the bit is set
    assign dbl_mod = pcal_pkg::mod_reduce({acc_q, 1'b0}, MODULUS);
    assign acc_nxt = a_sh_q[W-1] ? pcal_pkg::mod_reduce({1'b0, dbl_mod} + {1'b0, b_q}, MODULUS)
                                 : dbl_mod;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q  <= '0;
            busy_q <= 1'b0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                cnt_q  <= CNT_W'(W);
                busy_q <= 1'b1;
            end else if (busy_q) begin
                cnt_q <= cnt_q - CNT_W'(1);
                // last step lands with done
                if (cnt_q == CNT_W'(1)) begin
                    busy_q <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            acc_q  <= '0;
            a_sh_q <= a_i;
            b_q    <= b_i;
        end else if (busy_q) begin
            acc_q  <= acc_nxt;
            a_sh_q <= a_sh_q << 1;
        end
    end

    assign prod_o = acc_q;

endmodule

// File: verilog/mod_arith_lane.sv
`timescale 1ns/1ps

module mod_arith_lane #(
    parameter pcal_pkg::word_t MODULUS = pcal_pkg::SM2_P
) (
    input  logic                clk,
    input  logic                rst_n,
    input  pcal_pkg::lane_req_t req_i,
    output pcal_pkg::lane_rsp_t rsp_o
);

    localparam int W = pcal_pkg::DATA_W;

    logic [W:0]      sum_w;
    logic [W:0]      diff_w;
    pcal_pkg::word_t add_res;
    pcal_pkg::word_t sub_res;
    pcal_pkg::word_t mul_prod;
    pcal_pkg::word_t res_q;
    logic            mul_start;
    logic            mul_done;
    logic            done_q;
    logic            is_mul_q;

    ////////////////////
    // add / sub
    ////////////////////
    assign sum_w   = {1'b0, req_i.a} + {1'b0, req_i.b};
    assign add_res = pcal_pkg::mod_reduce(sum_w, MODULUS);

    // borrow out means wrap back above zero
    assign diff_w  = {1'b0, req_i.a} - {1'b0, req_i.b};
    assign sub_res = diff_w[W] ? diff_w[W-1:0] + MODULUS : diff_w[W-1:0];

    assign mul_start = req_i.start && req_i.op == pcal_pkg::OP_MUL;

    mod_mul_serial #(
        .MODULUS (MODULUS)
    ) u_mul (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (mul_start),
        .a_i     (req_i.a),
        .b_i     (req_i.b),
        .done_o  (mul_done),
        .prod_o  (mul_prod)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_q    <= '0;
            done_q   <= 1'b0;
            is_mul_q <= 1'b0;
        end else begin
            done_q <= req_i.start && req_i.op != pcal_pkg::OP_MUL;
            if (req_i.start) begin
                is_mul_q <= req_i.op == pcal_pkg::OP_MUL;
                case (req_i.op)
                    pcal_pkg::OP_ADD: res_q <= add_res;
                    pcal_pkg::OP_SUB: res_q <= sub_res;
                    pcal_pkg::OP_MUL: res_q <= res_q;
                    default:          res_q <= '0;
                endcase
            end
        end
    end

    // result holds until the next start
    assign rsp_o = '{done:   done_q | mul_done,
                     result: is_mul_q ? mul_prod : res_q};

endmodule

// File: verilog/pcal_ctrl.sv
`timescale 1ns/1ps

module pcal_ctrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  pcal_pkg::ins_bundle_t          ins_i,
    input  logic                           ins_vld_i,
    output pcal_pkg::ins_bundle_t          bundle_o,
    output logic [pcal_pkg::NUM_LANES-1:0] lane_start_o,
    input  pcal_pkg::lane_rsp_t            lane_rsp_i [pcal_pkg::NUM_LANES],
    output logic                           wb_en_o,
    output logic                           updt_en_o,
    output logic                           fin_en_o,
    output logic                           cal_done_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CAL,
        S_WAIT,
        S_WB,
        S_UPDT,
        S_FIN
    } state_t;

    state_t                         state_q;
    state_t                         state_d;
    logic [pcal_pkg::NUM_LANES-1:0] new_cal;
    logic [pcal_pkg::NUM_LANES-1:0] cal_mask;
    logic [pcal_pkg::NUM_LANES-1:0] done_vec;
    logic [pcal_pkg::NUM_LANES-1:0] pending_q;
    logic [pcal_pkg::NUM_LANES-1:0] pending_left;

    // slot decode for the incoming and the latched bundle
    always_comb begin
        for (int i = 0; i < pcal_pkg::NUM_LANES; i++) begin
            new_cal[i]  = ins_i.slot[i].ins_type == pcal_pkg::INS_CAL;
            cal_mask[i] = bundle_o.slot[i].ins_type == pcal_pkg::INS_CAL;
            done_vec[i] = lane_rsp_i[i].done;
        end
    end

    assign pending_left = pending_q & ~done_vec;

    ////////////////////
    // next state
    ////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                // slot 0 type decides, finish over update over calculation
                if (ins_vld_i) begin
                    if (ins_i.slot[0].ins_type == pcal_pkg::INS_FIN) begin
                        state_d = S_FIN;
                    end else if (ins_i.slot[0].ins_type == pcal_pkg::INS_UPDT_REG) begin
                        state_d = S_UPDT;
                    end else if (|new_cal) begin
                        state_d = S_CAL;
                    end
                end
            end
            S_CAL:   state_d = S_WAIT;
            S_WAIT: begin
                if (pending_left == '0) begin
                    state_d = S_WB;
                end
            end
            S_WB:    state_d = S_IDLE;
            S_UPDT:  state_d = S_IDLE;
            S_FIN:   state_d = S_IDLE;
            default: state_d = S_IDLE;
        endcase
    end

    assign lane_start_o = (state_q == S_CAL) ? cal_mask : '0;
    assign wb_en_o      = state_q == S_WB;
    assign updt_en_o    = state_q == S_UPDT;
    assign fin_en_o     = state_q == S_FIN;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= S_IDLE;
            pending_q  <= '0;
            cal_done_o <= 1'b0;
            bundle_o   <= '0;
        end else begin
            state_q    <= state_d;
            // done one cycle after writeback, outputs already updated
            cal_done_o <= wb_en_o;
            if (state_q == S_IDLE && ins_vld_i) begin
                bundle_o <= ins_i;
            end
            if (state_q == S_CAL) begin
                pending_q <= cal_mask;
            end else begin
                pending_q <= pending_left;
            end
        end
    end

endmodule

// File: verilog/pcal_regfile.sv
`timescale 1ns/1ps

module pcal_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pcal_pkg::ins_bundle_t bundle_i,
    input  logic                  wb_en_i,
    input  logic                  updt_en_i,
    input  logic                  fin_en_i,
    input  pcal_pkg::word_t       data_path_i,
    input  pcal_pkg::lane_rsp_t   lane_rsp_i [pcal_pkg::NUM_LANES],
    output pcal_pkg::word_t       opnd_o [pcal_pkg::NUM_LANES][2],
    output pcal_pkg::point_t      result_o
);

    localparam int NUM_VAR  = 6;
    localparam int NUM_CNST = 6;

    // x2 y2 z2 t0 t1 t2
    pcal_pkg::word_t    var_q  [NUM_VAR];
    // x0 y0 z0 x1 y1 z1
    pcal_pkg::word_t    cnst_q [NUM_CNST];
    // all sixteen register codes, unused codes are zero
    pcal_pkg::word_t    rd_view [16];
    pcal_pkg::reg_sel_t updt_id;
    logic [2:0]         cnst_idx;

    ////////////////////
    // operand select
    ////////////////////
    always_comb begin
        rd_view = '{default: '0};
        for (int i = 0; i < NUM_VAR; i++) begin
            rd_view[i] = var_q[i];
        end
        for (int i = 0; i < NUM_CNST; i++) begin
            rd_view[i + NUM_VAR] = cnst_q[i];
        end
    end

    always_comb begin
        for (int l = 0; l < pcal_pkg::NUM_LANES; l++) begin
            opnd_o[l][0] = rd_view[bundle_i.slot[l].body.cal.sel_a];
            opnd_o[l][1] = rd_view[bundle_i.slot[l].body.cal.sel_b];
        end
    end

    ////////////////////
    // variables
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_VAR; i++) begin
                var_q[i] <= '0;
            end
        end else if (wb_en_i) begin
            // highest slot first so the lowest slot lands last
            for (int s = pcal_pkg::NUM_LANES - 1; s >= 0; s--) begin
                if (bundle_i.slot[s].ins_type == pcal_pkg::INS_CAL &&
                    bundle_i.slot[s].body.cal.sel_r < pcal_pkg::SEL_X0) begin
                    var_q[bundle_i.slot[s].body.cal.sel_r[2:0]] <= lane_rsp_i[s].result;
                end
            end
        end
    end

    ////////////////////
    // constants
    ////////////////////
    assign updt_id  = bundle_i.slot[0].body.updt.reg_id;
    assign cnst_idx = 3'(updt_id - pcal_pkg::SEL_X0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnst_q[0] <= pcal_pkg::SM2_GX;
            cnst_q[1] <= pcal_pkg::SM2_GY;
            cnst_q[2] <= pcal_pkg::word_t'(1);
            cnst_q[3] <= pcal_pkg::SM2_GX;
            cnst_q[4] <= pcal_pkg::SM2_GY;
            cnst_q[5] <= pcal_pkg::word_t'(1);
        end else if (updt_en_i) begin
            // codes outside x0..z1 load nothing
            if (updt_id >= pcal_pkg::SEL_X0 && updt_id <= pcal_pkg::SEL_Z1) begin
                cnst_q[cnst_idx] <= data_path_i;
            end
        end else if (fin_en_i) begin
            // result point becomes the first input point
            cnst_q[0] <= var_q[0];
            cnst_q[1] <= var_q[1];
            cnst_q[2] <= var_q[2];
        end
    end

    assign result_o = '{x: var_q[0], y: var_q[1], z: var_q[2]};

endmodule

// File: verilog/point_cal_top.sv
`timescale 1ns/1ps

module point_cal_top #(
    parameter pcal_pkg::word_t MODULUS = pcal_pkg::SM2_P
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // instruction bundle
    input  pcal_pkg::ins_bundle_t ins_i,
    input  logic                  ins_vld_i,

    // constant load data
    input  pcal_pkg::word_t       data_path_i,

    output pcal_pkg::word_t       var_x2_o,
    output pcal_pkg::word_t       var_y2_o,
    output pcal_pkg::word_t       var_z2_o,
    output logic                  intr_cal_done_o
);

    pcal_pkg::ins_bundle_t                bundle;
    logic [pcal_pkg::NUM_LANES-1:0]       lane_start;
    logic                                 wb_en;
    logic                                 updt_en;
    logic                                 fin_en;
    pcal_pkg::word_t                      opnd [pcal_pkg::NUM_LANES][2];
    pcal_pkg::lane_req_t                  lane_req [pcal_pkg::NUM_LANES];
    pcal_pkg::lane_rsp_t                  lane_rsp [pcal_pkg::NUM_LANES];
    pcal_pkg::point_t                     result;

    ////////////////////
    // control
    ////////////////////
    pcal_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .ins_i        (ins_i),
        .ins_vld_i    (ins_vld_i),
        .bundle_o     (bundle),
        .lane_start_o (lane_start),
        .lane_rsp_i   (lane_rsp),
        .wb_en_o      (wb_en),
        .updt_en_o    (updt_en),
        .fin_en_o     (fin_en),
        .cal_done_o   (intr_cal_done_o)
    );

    ////////////////////
    // registers
    ////////////////////
    pcal_regfile u_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .bundle_i    (bundle),
        .wb_en_i     (wb_en),
        .updt_en_i   (updt_en),
        .fin_en_i    (fin_en),
        .data_path_i (data_path_i),
        .lane_rsp_i  (lane_rsp),
        .opnd_o      (opnd),
        .result_o    (result)
    );

    ////////////////////
    // lanes
    ////////////////////
    for (genvar i = 0; i < pcal_pkg::NUM_LANES; i++) begin : g_lane
        // start from the controller, operands from the register block
        assign lane_req[i] = '{start: lane_start[i],
                               op:    bundle.slot[i].op,
                               a:     opnd[i][0],
                               b:     opnd[i][1]};

        mod_arith_lane #(
            .MODULUS (MODULUS)
        ) u_lane (
            .clk   (clk),
            .rst_n (rst_n),
            .req_i (lane_req[i]),
            .rsp_o (lane_rsp[i])
        );
    end

    assign var_x2_o = result.x;
    assign var_y2_o = result.y;
    assign var_z2_o = result.z;

endmodule

// File: sim/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// (a + b) mod m, with a and b below m
function automatic pcal_pkg::word_t ref_add(input pcal_pkg::word_t a,
                                            input pcal_pkg::word_t b,
                                            input pcal_pkg::word_t m);
    logic [pcal_pkg::DATA_W:0] s;
    s = {1'b0, a} + {1'b0, b};
    if (s >= {1'b0, m}) begin
        s = s - {1'b0, m};
    end
    return s[pcal_pkg::DATA_W-1:0];
endfunction

// (a - b) mod m, computed as a + m - b
function automatic pcal_pkg::word_t ref_sub(input pcal_pkg::word_t a,
                                            input pcal_pkg::word_t b,
                                            input pcal_pkg::word_t m);
    logic [pcal_pkg::DATA_W:0] d;
    d = {1'b0, a} + {1'b0, m} - {1'b0, b};
    if (d >= {1'b0, m}) begin
        d = d - {1'b0, m};
    end
    return d[pcal_pkg::DATA_W-1:0];
endfunction

// full double-width product, then remainder
function automatic pcal_pkg::word_t ref_mul(input pcal_pkg::word_t a,
                                            input pcal_pkg::word_t b,
                                            input pcal_pkg::word_t m);
    logic [2*pcal_pkg::DATA_W-1:0] p;
    p = {{pcal_pkg::DATA_W{1'b0}}, a} * {{pcal_pkg::DATA_W{1'b0}}, b};
    p = p % {{pcal_pkg::DATA_W{1'b0}}, m};
    return p[pcal_pkg::DATA_W-1:0];
endfunction

`endif

// File: sim/tb_point_cal.sv
`timescale 1ns/1ps

module tb_point_cal;

    `include "tb_ref.svh"

    localparam int W          = pcal_pkg::DATA_W;
    localparam int DONE_LIMIT = W + 10;
    // about 40 operations of up to 270 cycles plus margin
    localparam int RUN_LIMIT  = 20000;
    localparam pcal_pkg::reg_sel_t SEL_ZERO = 4'd12;

    logic                  clk;
    logic                  rst_n;
    pcal_pkg::ins_bundle_t ins_i;
    logic                  ins_vld_i;
    pcal_pkg::word_t       data_path_i;
    pcal_pkg::word_t       var_x2_o;
    pcal_pkg::word_t       var_y2_o;
    pcal_pkg::word_t       var_z2_o;
    logic                  intr_cal_done_o;
    pcal_pkg::point_t      dut_point;

    // register model indexed by register code with 12..15 left at zero
    pcal_pkg::word_t model [16];
    integer          seed        = 68;
    int              done_count  = 0;
    int              cycle_count = 0;

    point_cal_top #(
        .MODULUS (pcal_pkg::SM2_P)
    ) uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .ins_i           (ins_i),
        .ins_vld_i       (ins_vld_i),
        .data_path_i     (data_path_i),
        .var_x2_o        (var_x2_o),
        .var_y2_o        (var_y2_o),
        .var_z2_o        (var_z2_o),
        .intr_cal_done_o (intr_cal_done_o)
    );

    assign dut_point = '{x: var_x2_o, y: var_y2_o, z: var_z2_o};

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////
    // checks
    ////////////////////
    task automatic stop_with_failure(input string why);
        $display("=== FAIL ===");
        $fatal(1, why);
    endtask

    task automatic check_word(input string name, input pcal_pkg::word_t got,
                              input pcal_pkg::word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure("register mismatch");
        end
    endtask

    task automatic check_point(input pcal_pkg::point_t got, input pcal_pkg::point_t exp);
        check_word("X2", got.x, exp.x);
        check_word("Y2", got.y, exp.y);
        check_word("Z2", got.z, exp.z);
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            stop_with_failure("count mismatch");
        end
    endtask

    function automatic pcal_pkg::point_t model_point();
        return '{x: model[pcal_pkg::SEL_X2], y: model[pcal_pkg::SEL_Y2],
                 z: model[pcal_pkg::SEL_Z2]};
    endfunction

    // compare at every done pulse
    always @(posedge clk) begin
        if (intr_cal_done_o) begin
            done_count = done_count + 1;
            check_point(dut_point, model_point());
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= RUN_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", RUN_LIMIT);
            stop_with_failure("run timeout");
        end
    end

    ////////////////////
    // instruction building
    ////////////////////
    function automatic pcal_pkg::ins_word_t cal_slot(input pcal_pkg::op_code_t op,
                                                     input pcal_pkg::reg_sel_t a,
                                                     input pcal_pkg::reg_sel_t b,
                                                     input pcal_pkg::reg_sel_t r);
        pcal_pkg::ins_word_t w;
        w                = '0;
        w.op             = op;
        w.ins_type       = pcal_pkg::INS_CAL;
        w.body.cal.sel_a = a;
        w.body.cal.sel_b = b;
        w.body.cal.sel_r = r;
        return w;
    endfunction

    function automatic pcal_pkg::ins_word_t ctl_slot(input pcal_pkg::ins_type_t t,
                                                     input pcal_pkg::reg_sel_t id);
        pcal_pkg::ins_word_t w;
        w                  = '0;
        w.ins_type         = t;
        w.body.updt.reg_id = id;
        return w;
    endfunction

    // type 3 is none of calculation, update or finish
    function automatic pcal_pkg::ins_word_t empty_slot();
        return ctl_slot(2'd3, 4'd0);
    endfunction

    function automatic pcal_pkg::ins_bundle_t make_bundle(input pcal_pkg::ins_word_t s0,
                                                          input pcal_pkg::ins_word_t s1,
                                                          input pcal_pkg::ins_word_t s2);
        pcal_pkg::ins_bundle_t b;
        b.slot[0] = s0;
        b.slot[1] = s1;
        b.slot[2] = s2;
        return b;
    endfunction

    task automatic rand_word(output pcal_pkg::word_t w);
        for (int i = 0; i < W / 32; i++) begin
            w[32*i +: 32] = $random(seed);
        end
        // one subtraction is enough since p is close to 2^256
        if (w >= pcal_pkg::SM2_P) begin
            w = w - pcal_pkg::SM2_P;
        end
    endtask

    ////////////////////
    // model and drive
    ////////////////////
    task automatic model_cal(input pcal_pkg::ins_bundle_t b);
        pcal_pkg::word_t     res [pcal_pkg::NUM_LANES];
        pcal_pkg::ins_word_t s;
        for (int i = 0; i < pcal_pkg::NUM_LANES; i++) begin
            s = b.slot[i];
            case (s.op)
                pcal_pkg::OP_MUL: res[i] = ref_mul(model[s.body.cal.sel_a],
                                                   model[s.body.cal.sel_b], pcal_pkg::SM2_P);
                pcal_pkg::OP_ADD: res[i] = ref_add(model[s.body.cal.sel_a],
                                                   model[s.body.cal.sel_b], pcal_pkg::SM2_P);
                pcal_pkg::OP_SUB: res[i] = ref_sub(model[s.body.cal.sel_a],
                                                   model[s.body.cal.sel_b], pcal_pkg::SM2_P);
                default:          res[i] = '0;
            endcase
        end
        // lowest slot written last so it wins
        for (int i = pcal_pkg::NUM_LANES - 1; i >= 0; i--) begin
            s = b.slot[i];
            if (s.ins_type == pcal_pkg::INS_CAL && s.body.cal.sel_r < pcal_pkg::SEL_X0) begin
                model[s.body.cal.sel_r] = res[i];
            end
        end
    endtask

    // one cycle of valid with data held until the next issue
    task automatic issue(input pcal_pkg::ins_bundle_t b, input pcal_pkg::word_t d);
        @(posedge clk);
        ins_i       <= b;
        data_path_i <= d;
        ins_vld_i   <= 1'b1;
        @(posedge clk);
        ins_vld_i   <= 1'b0;
    endtask

    task automatic run_cal(input pcal_pkg::ins_bundle_t b);
        int waited;
        int count_before;
        bit has_mul;
        has_mul = 1'b0;
        for (int i = 0; i < pcal_pkg::NUM_LANES; i++) begin
            if (b.slot[i].ins_type == pcal_pkg::INS_CAL && b.slot[i].op == pcal_pkg::OP_MUL) begin
                has_mul = 1'b1;
            end
        end
        model_cal(b);
        count_before = done_count;
        issue(b, '0);
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > DONE_LIMIT) begin
                $display("no done pulse within %0d cycles of the calculation", DONE_LIMIT);
                stop_with_failure("missing done pulse");
            end
        end while (!intr_cal_done_o);
        // cal cycle, slowest lane, writeback, then the done cycle
        check_count("done latency", waited, has_mul ? W + 4 : 4);
        repeat (3) @(posedge clk);
        check_count("done pulses", done_count, count_before + 1);
    endtask

    task automatic run_updt(input pcal_pkg::reg_sel_t id, input pcal_pkg::word_t d);
        int count_before;
        if (id >= pcal_pkg::SEL_X0 && id <= pcal_pkg::SEL_Z1) begin
            model[id] = d;
        end
        count_before = done_count;
        issue(make_bundle(ctl_slot(pcal_pkg::INS_UPDT_REG, id), empty_slot(), empty_slot()), d);
        repeat (3) @(posedge clk);
        check_count("done pulses", done_count, count_before);
    endtask

    task automatic run_fin();
        int count_before;
        model[pcal_pkg::SEL_X0] = model[pcal_pkg::SEL_X2];
        model[pcal_pkg::SEL_Y0] = model[pcal_pkg::SEL_Y2];
        model[pcal_pkg::SEL_Z0] = model[pcal_pkg::SEL_Z2];
        count_before = done_count;
        issue(make_bundle(ctl_slot(pcal_pkg::INS_FIN, 4'd0), empty_slot(), empty_slot()), '0);
        repeat (3) @(posedge clk);
        check_count("done pulses", done_count, count_before);
    endtask

    task automatic load_random(input pcal_pkg::reg_sel_t id);
        pcal_pkg::word_t v;
        rand_word(v);
        run_updt(id, v);
    endtask

    // copy three registers into X2, Y2 and Z2 by adding zero
    task automatic read_three(input pcal_pkg::reg_sel_t a, input pcal_pkg::reg_sel_t b,
                              input pcal_pkg::reg_sel_t c);
        run_cal(make_bundle(cal_slot(pcal_pkg::OP_ADD, a, SEL_ZERO, pcal_pkg::SEL_X2),
                            cal_slot(pcal_pkg::OP_ADD, b, SEL_ZERO, pcal_pkg::SEL_Y2),
                            cal_slot(pcal_pkg::OP_ADD, c, SEL_ZERO, pcal_pkg::SEL_Z2)));
    endtask

    ////////////////////
    // test sequence
    ////////////////////
    initial begin
        pcal_pkg::word_t v;
        rst_n       <= 1'b0;
        ins_i       <= '0;
        ins_vld_i   <= 1'b0;
        data_path_i <= '0;
        for (int i = 0; i < 16; i++) begin
            model[i] = '0;
        end
        model[pcal_pkg::SEL_X0] = pcal_pkg::SM2_GX;
        model[pcal_pkg::SEL_Y0] = pcal_pkg::SM2_GY;
        model[pcal_pkg::SEL_Z0] = pcal_pkg::word_t'(1);
        model[pcal_pkg::SEL_X1] = pcal_pkg::SM2_GX;
        model[pcal_pkg::SEL_Y1] = pcal_pkg::SM2_GY;
        model[pcal_pkg::SEL_Z1] = pcal_pkg::word_t'(1);
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // reset values and then the base point through X2 and Y2
        repeat (4) @(posedge clk);
        check_point(dut_point, model_point());
        check_count("done pulses", done_count, 0);
        run_cal(make_bundle(cal_slot(pcal_pkg::OP_ADD, pcal_pkg::SEL_X0, pcal_pkg::SEL_T0,
                                     pcal_pkg::SEL_X2),
                            cal_slot(pcal_pkg::OP_ADD, pcal_pkg::SEL_Y0, pcal_pkg::SEL_T0,
                                     pcal_pkg::SEL_Y2),
                            empty_slot()));

        // add and sub on fresh constants in both orders so one side wraps
        for (int r = 0; r < 3; r++) begin
            load_random(pcal_pkg::SEL_X1);
            load_random(pcal_pkg::SEL_Y1);
            load_random(pcal_pkg::SEL_Z1);
            run_cal(make_bundle(cal_slot(pcal_pkg::OP_ADD, pcal_pkg::SEL_X1, pcal_pkg::SEL_Y1,
                                         pcal_pkg::SEL_X2),
                                cal_slot(pcal_pkg::OP_SUB, pcal_pkg::SEL_X1, pcal_pkg::SEL_Y1,
                                         pcal_pkg::SEL_Y2),
                                cal_slot(pcal_pkg::OP_SUB, pcal_pkg::SEL_Y1, pcal_pkg::SEL_X1,
                                         pcal_pkg::SEL_Z2)));
            run_cal(make_bundle(cal_slot(pcal_pkg::OP_SUB, SEL_ZERO, pcal_pkg::SEL_Z1,
                                         pcal_pkg::SEL_X2),
                                cal_slot(pcal_pkg::OP_ADD, pcal_pkg::SEL_Z1, pcal_pkg::SEL_X1,
                                         pcal_pkg::SEL_Y2),
                                cal_slot(pcal_pkg::OP_SUB, pcal_pkg::SEL_Z1, pcal_pkg::SEL_Z1,
                                         pcal_pkg::SEL_Z2)));
        end

        // multiplies on all lanes
        for (int r = 0; r < 2; r++) begin
            load_random(pcal_pkg::SEL_X1);
            load_random(pcal_pkg::SEL_Y1);
            load_random(pcal_pkg::SEL_Z1);
            run_cal(make_bundle(cal_slot(pcal_pkg::OP_MUL, pcal_pkg::SEL_X1, pcal_pkg::SEL_Y1,
                                         pcal_pkg::SEL_X2),
                                cal_slot(pcal_pkg::OP_MUL, pcal_pkg::SEL_Y1, pcal_pkg::SEL_Z1,
                                         pcal_pkg::SEL_Y2),
                                cal_slot(pcal_pkg::OP_MUL, pcal_pkg::SEL_Z1, pcal_pkg::SEL_X1,
                                         pcal_pkg::SEL_Z2)));
        end
        // mixed lane latencies with done only after the multiply
        run_cal(make_bundle(cal_slot(pcal_pkg::OP_ADD, pcal_pkg::SEL_X2, pcal_pkg::SEL_Y2,
                                     pcal_pkg::SEL_X2),
                            empty_slot(),
                            cal_slot(pcal_pkg::OP_MUL, pcal_pkg::SEL_Y2, pcal_pkg::SEL_Z2,
                                     pcal_pkg::SEL_Z2)));

        // same target twice and a constant target whose low bits alias Z2
        run_cal(make_bundle(cal_slot(pcal_pkg::OP_ADD, pcal_pkg::SEL_X1, pcal_pkg::SEL_Y1,
                                     pcal_pkg::SEL_Y2),
                            cal_slot(pcal_pkg::OP_SUB, pcal_pkg::SEL_X1, pcal_pkg::SEL_Y1,
                                     pcal_pkg::SEL_Y2),
                            cal_slot(pcal_pkg::OP_ADD, pcal_pkg::SEL_Z1, pcal_pkg::SEL_Z1,
                                     pcal_pkg::SEL_Y1)));
        read_three(pcal_pkg::SEL_Y1, pcal_pkg::SEL_Y2, pcal_pkg::SEL_Z1);

        // finish copies the result point into X0..Z0
        run_fin();
        run_cal(make_bundle(cal_slot(pcal_pkg::OP_MUL, pcal_pkg::SEL_X1, pcal_pkg::SEL_Y1,
                                     pcal_pkg::SEL_X2),
                            cal_slot(pcal_pkg::OP_SUB, pcal_pkg::SEL_Y1, pcal_pkg::SEL_Z1,
                                     pcal_pkg::SEL_Y2),
                            cal_slot(pcal_pkg::OP_ADD, pcal_pkg::SEL_Z1, pcal_pkg::SEL_Z1,
                                     pcal_pkg::SEL_Z2)));
        read_three(pcal_pkg::SEL_X0, pcal_pkg::SEL_Y0, pcal_pkg::SEL_Z0);

        // updates to codes that are not constants are ignored
        rand_word(v);
        run_updt(SEL_ZERO, v);
        rand_word(v);
        run_updt(pcal_pkg::SEL_T0, v);
        read_three(pcal_pkg::SEL_X0, pcal_pkg::SEL_Y0, pcal_pkg::SEL_Z0);
        read_three(pcal_pkg::SEL_X1, pcal_pkg::SEL_Y1, pcal_pkg::SEL_Z1);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: all.f
verilog/pcal_pkg.sv
verilog/mod_mul_serial.sv
verilog/mod_arith_lane.sv
verilog/pcal_ctrl.sv
verilog/pcal_regfile.sv
verilog/point_cal_top.sv
sim/tb_point_cal.sv
+incdir+sim

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_point_cal -f all.f -o sim_point_cal
./obj_dir/sim_point_cal | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
